// File: load_store_unit.sv
// Two-stage memory execute unit: request stage, then response stage
// Address is op1 + op2; the low two bits are passed on but unused downstream
// At most two operations in flight, one per stage
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
  import uarch_pkg::*, mem_msg_pkg::*;
#(
  parameter int seq_num_bits   = SEQ_NUM_BITS,
  parameter int phys_addr_bits = PHYS_ADDR_BITS
) (
  input  logic                      clk,
  input  logic                      rst,

  // Issue side
  input  logic                      d_val,
  output logic                      d_rdy,
  input  rv_uop                     d_uop,
  input  logic [31:0]               d_pc,
  input  logic [seq_num_bits-1:0]   d_seq_num,
  input  logic [31:0]               d_op1,
  input  logic [31:0]               d_op2,
  input  logic [ARCH_ADDR_BITS-1:0] d_waddr,
  input  logic [phys_addr_bits-1:0] d_preg,
  input  logic [phys_addr_bits-1:0] d_ppreg,
  input  logic [31:0]               d_mem_data,

  // Memory request
  output logic                      mem_req_val,
  input  logic                      mem_req_rdy,
  output mem_op_t                   mem_req_op,
  output logic [MEM_DATA_BITS-1:0]  mem_req_addr,
  output logic [MEM_DATA_BITS-1:0]  mem_req_data,

  // Memory response
  input  logic                      mem_resp_val,
  output logic                      mem_resp_rdy,
  input  logic [MEM_DATA_BITS-1:0]  mem_resp_data,

  // Writeback side
  output logic                      w_val,
  input  logic                      w_rdy,
  output logic [31:0]               w_pc,
  output logic [seq_num_bits-1:0]   w_seq_num,
  output logic [ARCH_ADDR_BITS-1:0] w_waddr,
  output logic [phys_addr_bits-1:0] w_preg,
  output logic [phys_addr_bits-1:0] w_ppreg,
  output logic                      w_wen,
  output logic [31:0]               w_wdata
);

  // --------------------------------------
  // Request stage state
  // --------------------------------------

  logic                      req_val;       // Stage holds an issued uop
  rv_uop                     req_uop;
  logic [31:0]               req_pc;
  logic [seq_num_bits-1:0]   req_seq_num;
  logic [31:0]               req_op1;
  logic [31:0]               req_op2;
  logic [ARCH_ADDR_BITS-1:0] req_waddr;
  logic [phys_addr_bits-1:0] req_preg;
  logic [phys_addr_bits-1:0] req_ppreg;
  logic [31:0]               req_mem_data;  // Store data

  // --------------------------------------
  // Response stage state
  // --------------------------------------

  logic                      resp_val;      // Waiting on memory response
  logic [31:0]               resp_pc;
  logic [seq_num_bits-1:0]   resp_seq_num;
  logic [ARCH_ADDR_BITS-1:0] resp_waddr;
  logic [phys_addr_bits-1:0] resp_preg;
  logic [phys_addr_bits-1:0] resp_ppreg;
  logic                      resp_wen;

  // Handshake glue
  logic d_xfer;
  logic req_xfer;   // Request stage moves into response stage
  logic w_xfer;
  logic resp_adv;   // Response stage free to take a new entry

  // Response stage drains this cycle, or is already empty
  assign resp_adv = !resp_val || (mem_resp_val && w_rdy);

  assign d_rdy    = !req_val || (mem_req_rdy && resp_adv);
  assign d_xfer   = d_val && d_rdy;

  assign mem_req_val = req_val && resp_adv;
  assign req_xfer    = mem_req_val && mem_req_rdy;

  assign w_val  = resp_val && mem_resp_val;  // Tags plus data both present
  assign w_xfer = w_val && w_rdy;

  // Memory response accepted together with the writeback
  assign mem_resp_rdy = resp_val && w_rdy;

  // --------------------------------------
  // Request stage
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      req_val <= 1'b0;
    end else if (d_xfer) begin
      req_val <= 1'b1;              // Load, possibly while draining
    end else if (req_xfer) begin
      req_val <= 1'b0;
    end
  end

  // Payload only, captured on issue
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      req_uop      <= d_uop;
      req_pc       <= d_pc;
      req_seq_num  <= d_seq_num;
      req_op1      <= d_op1;
      req_op2      <= d_op2;
      req_waddr    <= d_waddr;
      req_preg     <= d_preg;
      req_ppreg    <= d_ppreg;
      req_mem_data <= d_mem_data;
    end
  end

  // Address generation and request fields
  assign mem_req_addr = req_op1 + req_op2;
  assign mem_req_data = req_mem_data;

  always_comb begin
    case (req_uop)
      OP_SW:   mem_req_op = MEM_MSG_WRITE;
      default: mem_req_op = MEM_MSG_READ;   // OP_LW
    endcase
  end

  // --------------------------------------
  // Response stage
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_val <= 1'b0;
    end else if (req_xfer) begin
      resp_val <= 1'b1;
    end else if (w_xfer) begin
      resp_val <= 1'b0;
    end
  end

  // Writeback tags ride alongside the memory access
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      resp_pc      <= req_pc;
      resp_seq_num <= req_seq_num;
      resp_waddr   <= req_waddr;
      resp_preg    <= req_preg;
      resp_ppreg   <= req_ppreg;
      resp_wen     <= (req_uop == OP_LW);  // Stores write no register
    end
  end

  // Writeback fields
  assign w_pc      = resp_pc;
  assign w_seq_num = resp_seq_num;
  assign w_waddr   = resp_waddr;
  assign w_preg    = resp_preg;
  assign w_ppreg   = resp_ppreg;
  assign w_wen     = resp_wen;
  assign w_wdata   = mem_resp_data;   // Old word for stores, ignored there

endmodule

`default_nettype wire

// File: lsu_subsystem.f
uarch_pkg.sv
mem_msg_pkg.sv
load_store_unit.sv
test_memory.sv
lsu_subsystem.sv
lsu_subsystem_assertions.sv
lsu_subsystem_tb.sv

// File: lsu_subsystem.sv
// Load/store unit joined to its test memory
// Parameters set here reach both children; there is no other logic
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem
  import uarch_pkg::*, mem_msg_pkg::*;
#(
  parameter int seq_num_bits   = SEQ_NUM_BITS,
  parameter int phys_addr_bits = PHYS_ADDR_BITS,
  parameter int mem_words      = 256
) (
  input  logic                      clk,
  input  logic                      rst,

  // Issue side
  input  logic                      d_val,
  output logic                      d_rdy,
  input  rv_uop                     d_uop,
  input  logic [31:0]               d_pc,
  input  logic [seq_num_bits-1:0]   d_seq_num,
  input  logic [31:0]               d_op1,
  input  logic [31:0]               d_op2,
  input  logic [ARCH_ADDR_BITS-1:0] d_waddr,
  input  logic [phys_addr_bits-1:0] d_preg,
  input  logic [phys_addr_bits-1:0] d_ppreg,
  input  logic [31:0]               d_mem_data,

  // Writeback side
  output logic                      w_val,
  input  logic                      w_rdy,
  output logic [31:0]               w_pc,
  output logic [seq_num_bits-1:0]   w_seq_num,
  output logic [ARCH_ADDR_BITS-1:0] w_waddr,
  output logic [phys_addr_bits-1:0] w_preg,
  output logic [phys_addr_bits-1:0] w_ppreg,
  output logic                      w_wen,
  output logic [31:0]               w_wdata
);

  // --------------------------------------
  // Memory link
  // --------------------------------------

  logic                     mem_req_val;
  logic                     mem_req_rdy;
  mem_op_t                  mem_req_op;
  logic [MEM_DATA_BITS-1:0] mem_req_addr;
  logic [MEM_DATA_BITS-1:0] mem_req_data;
  logic                     mem_resp_val;
  logic                     mem_resp_rdy;
  logic [MEM_DATA_BITS-1:0] mem_resp_data;

  load_store_unit #(
    .seq_num_bits   (seq_num_bits),
    .phys_addr_bits (phys_addr_bits)
  ) lsu0 (
    .clk, .rst,
    .d_val, .d_rdy, .d_uop, .d_pc, .d_seq_num, .d_op1, .d_op2,
    .d_waddr, .d_preg, .d_ppreg, .d_mem_data,
    .mem_req_val, .mem_req_rdy, .mem_req_op, .mem_req_addr, .mem_req_data,
    .mem_resp_val, .mem_resp_rdy, .mem_resp_data,
    .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_preg, .w_ppreg,
    .w_wen, .w_wdata
  );

  test_memory #(
    .mem_words (mem_words)
  ) mem0 (
    .clk, .rst,
    .mem_req_val, .mem_req_rdy, .mem_req_op, .mem_req_addr, .mem_req_data,
    .mem_resp_val, .mem_resp_rdy, .mem_resp_data
  );

endmodule

`default_nettype wire

// File: lsu_subsystem_assertions.sv
// Handshake checks for the load/store unit attached with bind
// Widths follow the bound instance through its own parameters
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem_assertions #(
  parameter int seq_num_bits   = 6,
  parameter int phys_addr_bits = 6
) (
  input logic                      clk,
  input logic                      rst,
  input logic                      d_rdy,
  input logic                      mem_req_op,
  input logic [31:0]               mem_req_addr,
  input logic [31:0]               mem_req_data,
  input logic                      w_val,
  input logic                      w_rdy,
  input logic [31:0]               w_pc,
  input logic [seq_num_bits-1:0]   w_seq_num,
  input logic [4:0]                w_waddr,
  input logic [phys_addr_bits-1:0] w_preg,
  input logic [phys_addr_bits-1:0] w_ppreg,
  input logic                      w_wen,
  input logic [31:0]               w_wdata
);

  // Ready to issue and nothing to write back in the first cycle out of reset
  reset_exit_state: assert property (@(posedge clk) $past(rst) && !rst |-> d_rdy && !w_val)
    else $error("Unit not idle in the first cycle after reset");

  // Writeback held while the receiver stalls
  writeback_stable: assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable(w_pc) && $stable(w_seq_num) && $stable(w_waddr)
      && $stable(w_preg) && $stable(w_ppreg) && $stable(w_wen) && $stable(w_wdata))
    else $error("Writeback fields changed while stalled");

  // Full request stage that cannot advance keeps its memory request
  mem_req_stable: assert property (@(posedge clk) disable iff (rst)
    !d_rdy |=> $stable(mem_req_op) && $stable(mem_req_addr) && $stable(mem_req_data))
    else $error("Memory request fields changed while stalled");

endmodule

bind load_store_unit lsu_subsystem_assertions #(
  .seq_num_bits   (seq_num_bits),
  .phys_addr_bits (phys_addr_bits)
) asrt0 (
  .clk, .rst, .d_rdy,
  .mem_req_op, .mem_req_addr, .mem_req_data,
  .w_val, .w_rdy, .w_pc, .w_seq_num, .w_waddr, .w_preg, .w_ppreg, .w_wen, .w_wdata
);

`default_nettype wire

// File: lsu_subsystem_stimulus.txt
# group uop(0=LW 1=SW) pc seq op1 op2 waddr preg ppreg mem_data exp_wdata
# group is decimal, the rest hex; exp_wdata is the old word for stores
0 1 00001000 01 00000100 00000000 00 00 00 a0a0a0a0 00000000
0 1 00001004 02 00000104 00000000 00 00 00 b1b1b1b1 00000000
0 1 00001008 03 00000200 00000000 00 00 00 c2c2c2c2 00000000
0 1 0000100c 04 000003fc 00000000 00 00 00 d3d3d3d3 00000000
1 1 00001010 05 00000100 00000000 01 01 02 12345678 a0a0a0a0
1 0 00001014 06 00000100 00000000 0a 11 21 00000000 12345678
1 1 00001018 07 00000104 00000000 02 03 04 87654321 b1b1b1b1
1 0 0000101c 08 00000104 00000000 0b 12 22 00000000 87654321
2 0 00001020 09 000001f0 00000010 0c 13 23 00000000 c2c2c2c2
2 1 00001024 0a 00000000 00000200 03 05 06 5a5a5a5a c2c2c2c2
2 0 00001028 0b ffffff00 00000300 0d 14 24 00000000 5a5a5a5a
2 1 0000102c 0c 00000500 00000100 04 07 08 6b6b6b6b 5a5a5a5a
2 0 00001030 0d 00000201 00000002 0e 15 25 00000000 6b6b6b6b
3 0 00001040 10 000003f0 0000000c 01 16 26 00000000 d3d3d3d3
3 1 00001044 11 000003fc 00000000 05 09 0a e4e4e4e4 d3d3d3d3
3 0 00001048 12 000003fc 00000000 0f 17 27 00000000 e4e4e4e4
3 0 0000104c 13 00000100 00000000 10 18 28 00000000 12345678
3 0 00001050 14 00000104 00000000 11 19 29 00000000 87654321
3 1 00001054 15 00000100 00000000 06 0b 0c f5f5f5f5 12345678
4 0 00001060 18 00000100 00000000 12 1a 2a 00000000 f5f5f5f5
4 1 00001064 19 00000104 00000000 07 0d 0e 01020304 87654321
4 0 00001068 1a 00000104 00000000 13 1b 2b 00000000 01020304
4 1 0000106c 1b 00000200 00000000 08 0f 10 0a0b0c0d 6b6b6b6b
4 0 00001070 1c 000001fc 00000004 14 1c 2c 00000000 0a0b0c0d
4 0 00001074 1d 000003fc 00000000 15 1d 2d 00000000 e4e4e4e4
4 1 00001078 1e 000003fc 00000000 09 11 12 11223344 e4e4e4e4
4 0 0000107c 1f 000003f8 00000004 16 1e 2e 00000000 11223344
4 0 00001080 20 00000100 00000000 17 1f 2f 00000000 f5f5f5f5
4 0 00001084 21 00000200 00000000 18 20 30 00000000 0a0b0c0d

// File: lsu_subsystem_tb.sv
// Testbench for the load/store subsystem with stimulus read from a text file
// Group 0 stores initialize memory; their old-word data is not checked
// All waits are bounded by a cycle timeout
`timescale 1ns/1ps
`default_nettype none

module lsu_subsystem_tb import uarch_pkg::*; ();

  localparam int SEQ      = SEQ_NUM_BITS;
  localparam int PHYS     = PHYS_ADDR_BITS;
  localparam int MAX_OPS  = 64;
  localparam int TIMEOUT  = 100;   // Cycles per wait

  logic clk;
  logic rst;
  logic d_val, d_rdy, w_val, w_rdy, w_wen;
  rv_uop d_uop;
  logic [31:0] d_pc, d_op1, d_op2, d_mem_data, w_pc, w_wdata;
  logic [SEQ-1:0] d_seq_num, w_seq_num;
  logic [4:0] d_waddr, w_waddr;
  logic [PHYS-1:0] d_preg, d_ppreg, w_preg, w_ppreg;

  // Stimulus table with one entry per file line
  int          s_group [MAX_OPS];
  logic [31:0] s_uop [MAX_OPS], s_pc [MAX_OPS], s_seq [MAX_OPS], s_op1 [MAX_OPS];
  logic [31:0] s_op2 [MAX_OPS], s_waddr [MAX_OPS], s_preg [MAX_OPS], s_ppreg [MAX_OPS];
  logic [31:0] s_data [MAX_OPS], s_exp [MAX_OPS];
  int          n_ops = 0;
  int          is_cyc [MAX_OPS];   // Cycle of each issue transfer

  // Accepted writebacks in arrival order
  logic [31:0] wb_pc [MAX_OPS], wb_seq [MAX_OPS], wb_waddr [MAX_OPS], wb_preg [MAX_OPS];
  logic [31:0] wb_ppreg [MAX_OPS], wb_wen [MAX_OPS], wb_wdata [MAX_OPS];
  int          wb_cyc [MAX_OPS];
  int          wb_count = 0;

  int     cyc = 0;
  int     test_err, pass_cnt = 0, fail_cnt = 0;
  bit     rand_ready = 1'b0;
  integer seed = 32'h4fe4;

  lsu_subsystem dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Writeback ready held high or randomized in the back-pressure phase
  initial begin
    logic [31:0] rnd;
    w_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (rand_ready) begin
        rnd = $random(seed);
        w_rdy = rnd[0];
      end else begin
        w_rdy = 1'b1;
      end
    end
  end

  // Monitor samples mid-cycle where the handshake is settled
  always @(negedge clk) begin
    if (!rst && w_val && w_rdy) begin
      if (wb_count < MAX_OPS) begin
        wb_pc[wb_count]    = w_pc;
        wb_seq[wb_count]   = 32'(w_seq_num);
        wb_waddr[wb_count] = 32'(w_waddr);
        wb_preg[wb_count]  = 32'(w_preg);
        wb_ppreg[wb_count] = 32'(w_ppreg);
        wb_wen[wb_count]   = 32'(w_wen);
        wb_wdata[wb_count] = w_wdata;
        wb_cyc[wb_count]   = cyc;
      end
      wb_count = wb_count + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      test_err = test_err + 1;
    end
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      pass_cnt = pass_cnt + 1;
      $display("[ok]   %s", name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("[fail] %s: %0d errors", name, test_err);
    end
  endtask

  // Drive one op from 1 ns after an edge until d_rdy takes it
  task automatic issue_op(input int i, output bit ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    d_val      = 1'b1;
    d_uop      = rv_uop'(s_uop[i][0]);
    d_pc       = s_pc[i];
    d_seq_num  = s_seq[i][SEQ-1:0];
    d_op1      = s_op1[i];
    d_op2      = s_op2[i];
    d_waddr    = s_waddr[i][4:0];
    d_preg     = s_preg[i][PHYS-1:0];
    d_ppreg    = s_ppreg[i][PHYS-1:0];
    d_mem_data = s_data[i];
    while (!ok && waited < TIMEOUT) begin
      @(negedge clk);
      if (d_rdy) begin
        is_cyc[i] = cyc;
        ok = 1'b1;
      end
      @(posedge clk);
      #1;
      waited = waited + 1;
    end
    d_val = 1'b0;
    if (!ok) begin
      $display("Timeout waiting for d_rdy on op %0d", i);
      test_err = test_err + 1;
    end
  endtask

  // Issue every op of one group back to back, then check its writebacks
  task automatic run_group(input int g, input string name, input bit timing);
    int lines[$];
    int base, waited, k, ln;
    bit ok;
    @(posedge clk);
    #1;
    test_err = 0;
    base = wb_count;
    ok = 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      if (s_group[i] == g && ok) begin
        issue_op(i, ok);
        lines.push_back(i);
      end
    end
    waited = 0;
    while (wb_count < base + lines.size() && waited < TIMEOUT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (wb_count < base + lines.size()) begin
      $display("Timeout waiting for writeback in %s", name);
      test_err = test_err + 1;
    end
    repeat (4) @(negedge clk);   // Catch any extra writeback
    if (wb_count > base + lines.size()) begin
      $display("Unexpected extra writebacks in %s", name);
      test_err = test_err + 1;
    end
    for (int j = 0; j < lines.size() && base + j < wb_count; j++) begin
      k  = base + j;
      ln = lines[j];
      check_value("w_pc", wb_pc[k], s_pc[ln]);
      check_value("w_seq_num", wb_seq[k], s_seq[ln]);
      check_value("w_waddr", wb_waddr[k], s_waddr[ln]);
      check_value("w_preg", wb_preg[k], s_preg[ln]);
      check_value("w_ppreg", wb_ppreg[k], s_ppreg[ln]);
      check_value("w_wen", wb_wen[k], 32'(s_uop[ln][0] == 1'b0));   // Loads only
      if (g != 0) check_value("w_wdata", wb_wdata[k], s_exp[ln]);
      if (timing) begin
        check_value("writeback latency", 32'(wb_cyc[k] - is_cyc[ln]), 32'd2);
        if (j > 0) check_value("issue spacing", 32'(is_cyc[ln] - is_cyc[lines[j-1]]), 32'd1);
      end
    end
    end_test(name);
  endtask

  initial begin
    int fd, rc, t_group;
    string line_s;
    logic [31:0] t_uop, t_pc, t_seq, t_op1, t_op2, t_waddr, t_preg, t_ppreg, t_data, t_exp;
    rst = 1'b1;
    d_val = 1'b0;
    d_uop = OP_LW;
    d_pc = '0;
    d_seq_num = '0;
    d_op1 = '0;
    d_op2 = '0;
    d_waddr = '0;
    d_preg = '0;
    d_ppreg = '0;
    d_mem_data = '0;

    // ----------------------------------------
    // Load stimulus
    // ----------------------------------------
    fd = $fopen("lsu_subsystem_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      fail_cnt = fail_cnt + 1;
    end else begin
      while (!$feof(fd) && n_ops < MAX_OPS) begin
        rc = $fgets(line_s, fd);
        if (rc > 0 && line_s[0] != "#") begin
          rc = $sscanf(line_s, "%d %h %h %h %h %h %h %h %h %h %h", t_group, t_uop, t_pc,
                       t_seq, t_op1, t_op2, t_waddr, t_preg, t_ppreg, t_data, t_exp);
          if (rc == 11) begin
            s_group[n_ops] = t_group;
            s_uop[n_ops]   = t_uop;
            s_pc[n_ops]    = t_pc;
            s_seq[n_ops]   = 32'(t_seq[SEQ-1:0]);
            s_op1[n_ops]   = t_op1;
            s_op2[n_ops]   = t_op2;
            s_waddr[n_ops] = 32'(t_waddr[4:0]);
            s_preg[n_ops]  = 32'(t_preg[PHYS-1:0]);
            s_ppreg[n_ops] = 32'(t_ppreg[PHYS-1:0]);
            s_data[n_ops]  = t_data;
            s_exp[n_ops]   = t_exp;
            n_ops = n_ops + 1;
          end
        end
      end
      $fclose(fd);
    end

    // ----------------------------------------
    // Reset for 4 cycles
    // ----------------------------------------
    test_err = 0;
    repeat (3) begin
      @(negedge clk);
      check_value("w_val", 32'(w_val), 32'd0);
      check_value("d_rdy", 32'(d_rdy), 32'd1);
    end
    @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_value("w_val", 32'(w_val), 32'd0);
    check_value("d_rdy", 32'(d_rdy), 32'd1);
    end_test("reset state");

    run_group(0, "memory setup stores", 1'b0);
    run_group(1, "store then load", 1'b0);
    run_group(2, "address split and wrap", 1'b0);
    run_group(3, "back-to-back timing", 1'b1);
    rand_ready = 1'b1;
    run_group(4, "random writeback stall", 1'b0);
    rand_ready = 1'b0;

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && n_ops > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_msg_pkg.sv
// Memory request definitions shared by the execute unit and the test memory
// Requests are whole words; there is no length or opaque field
`default_nettype none

package mem_msg_pkg;

  // --------------------------------------
  // Request kind
  // --------------------------------------

  // Read returns the addressed word
  // Write stores the new word and returns the old one
  typedef enum logic [0:0] {
    MEM_MSG_READ  = 1'b0,
    MEM_MSG_WRITE = 1'b1
  } mem_op_t;

  // --------------------------------------
  // Widths
  // --------------------------------------

  // Address and data width of the memory port
  // Byte addressed; the low two bits select nothing
  localparam int MEM_DATA_BITS = 32;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lsu_subsystem_tb \
  -f lsu_subsystem.f -o lsu_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log
grep -q "^STATUS: PASS$" sim.log \
  && echo "Run succeeded" \
  || { echo "Run failed, see sim.log"; exit 1; }

// File: test_memory.sv
// Word-addressed test memory, one request accepted per cycle
// Address bits above the array size wrap; the low two bits are ignored
// mem_words must be a power of two, at least 2; contents are not reset
`timescale 1ns/1ps
`default_nettype none

module test_memory
  import mem_msg_pkg::*;
#(
  parameter int mem_words = 256
) (
  input  logic                     clk,
  input  logic                     rst,

  // Request
  input  logic                     mem_req_val,
  output logic                     mem_req_rdy,
  input  mem_op_t                  mem_req_op,
  input  logic [MEM_DATA_BITS-1:0] mem_req_addr,
  input  logic [MEM_DATA_BITS-1:0] mem_req_data,

  // Response
  output logic                     mem_resp_val,
  input  logic                     mem_resp_rdy,
  output logic [MEM_DATA_BITS-1:0] mem_resp_data
);

  localparam int idx_bits = $clog2(mem_words);

  // --------------------------------------
  // Storage
  // --------------------------------------

  logic [MEM_DATA_BITS-1:0] mem_array [mem_words];

  logic [idx_bits-1:0]      req_idx;    // Word index into the array
  logic                     req_xfer;
  logic                     resp_xfer;

  // Response register
  logic                     resp_val_q;
  logic [MEM_DATA_BITS-1:0] resp_data_q;

  // Drop byte offset, keep enough word bits to wrap
  assign req_idx = mem_req_addr[2 +: idx_bits];

  // --------------------------------------
  // Handshake
  // --------------------------------------

  assign resp_xfer = resp_val_q && mem_resp_rdy;

  // Accept when the response slot is free or freed this cycle
  assign mem_req_rdy = !resp_val_q || resp_xfer;
  assign req_xfer    = mem_req_val && mem_req_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_val_q <= 1'b0;
    end else if (req_xfer) begin
      resp_val_q <= 1'b1;          // New answer replaces taken one
    end else if (resp_xfer) begin
      resp_val_q <= 1'b0;
    end
  end

  // --------------------------------------
  // Array access
  // --------------------------------------

  // Both kinds return the word as it was before this request
  always_ff @(posedge clk) begin
    if (req_xfer) begin
      resp_data_q <= mem_array[req_idx];
      if (mem_req_op == MEM_MSG_WRITE) begin
        mem_array[req_idx] <= mem_req_data;
      end
    end
  end

  assign mem_resp_val  = resp_val_q;
  assign mem_resp_data = resp_data_q;   // Held until taken

endmodule

`default_nettype wire

// File: uarch_pkg.sv
// Micro-op and pipeline width definitions for the memory execute path
// Only word loads and stores are modeled; sub-word uops do not exist here
`default_nettype none

package uarch_pkg;

  // --------------------------------------
  // Micro-ops
  // --------------------------------------

  // Memory micro-ops issued to the load/store unit
  // LW writes back a register, SW only updates memory
  typedef enum logic [0:0] {
    OP_LW = 1'b0,  // Load word
    OP_SW = 1'b1   // Store word
  } rv_uop;

  // --------------------------------------
  // Widths
  // --------------------------------------

  // Default reorder sequence-number width
  // The top level overrides it through seq_num_bits
  localparam int SEQ_NUM_BITS = 6;

  // Default physical register tag width
  // Passed down as phys_addr_bits
  localparam int PHYS_ADDR_BITS = 6;

  // Architectural register index width, fixed by the ISA
  // 32 integer registers
  localparam int ARCH_ADDR_BITS = 5;

endpackage

`default_nettype wire
